// File: logic/rv32i_types_pkg.sv
`default_nettype none

package rv32i_types_pkg;

  // Data and address words are always 32 bits wide in RV32I
  typedef logic [31:0] rv32i_word;

  // Control fields set up by decode and carried down the pipeline
  typedef struct packed {
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       read;
    logic       write;
    logic       load_regfile;
    logic [4:0] rd;
  } rv32i_control_word;

  // One instruction word seen either as an I-type load or as an S-type store
  typedef union packed {
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } ld;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } st;
  } rv32i_instr;

  // Everything the writeback stage needs from the memory stage
  typedef struct packed {
    rv32i_control_word ctrl;
    rv32i_instr        instr;
    rv32i_word         pc;
    rv32i_word         pc_plus4;
    rv32i_word         alu_out;
    rv32i_word         load_data;
    rv32i_word         store_data;
    rv32i_word         data_addr;
    logic              br_en;
  } mem_wb_t;

  // Width codes shared by loads and stores in funct3
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  localparam logic [6:0] OP_LOAD  = 7'b0000011;
  localparam logic [6:0] OP_STORE = 7'b0100011;

  // addi x0, x0, 0
  localparam rv32i_word NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire

// File: logic/mem_stage_ctrl.sv
`default_nettype none

module mem_stage_ctrl (
  input  logic                               clk,
  input  logic                               rst,
  input  rv32i_types_pkg::rv32i_control_word ctrl,
  input  logic                               data_resp,
  output logic                               data_read,
  output logic                               data_write,
  output logic                               stall,
  output logic                               advance,
  output logic                               bubble
);

  logic request;
  logic pending;

  // Strobes follow the EX/MEM control word directly
  assign data_read  = ctrl.read;
  assign data_write = ctrl.write;

  assign request = ctrl.read | ctrl.write;

  // The stage waits until the memory answers the current request
  assign stall = request & ~data_resp;

  // MEM/WB loads new contents on every edge that is not stalled
  assign advance = ~stall;

  // The first waiting edge clears MEM/WB to a bubble.
  // Later waiting edges just hold it, so the register keeps showing a NOP
  assign bubble = stall & ~pending;

  // Set for every cycle that follows a waiting edge of the same access
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
    end else begin
      pending <= stall;
    end
  end

endmodule

`default_nettype wire

// File: logic/store_align.sv
`default_nettype none

module store_align (
  input  logic [2:0]                 funct3,
  input  logic [1:0]                 offset,
  input  rv32i_types_pkg::rv32i_word store_src,
  output logic [3:0]                 data_mbe,
  output rv32i_types_pkg::rv32i_word data_wdata
);

  import rv32i_types_pkg::*;

  logic [3:0] base_mask;
  logic [4:0] shift_bits;

  // Byte lanes covered by the store before it is moved to its offset
  always_comb begin
    case (funct3)
      F3_B: begin
        base_mask = 4'b0001;
      end
      F3_H: begin
        base_mask = 4'b0011;
      end
      F3_W: begin
        base_mask = 4'b1111;
      end
      default: begin
        base_mask = 4'b1111;
      end
    endcase
  end

  assign data_mbe = base_mask << offset;

  // Eight bits per byte of offset
  assign shift_bits = {offset, 3'b000};

  // Low bytes of the source end up in the lanes named by the mask.
  // Bytes shifted into the unmasked lanes are ignored by the memory
  assign data_wdata = store_src << shift_bits;

endmodule

`default_nettype wire

// File: logic/load_extract.sv
`default_nettype none

module load_extract (
  input  logic [2:0]                 funct3,
  input  logic [1:0]                 offset,
  input  rv32i_types_pkg::rv32i_word data_rdata,
  output rv32i_types_pkg::rv32i_word load_data
);

  import rv32i_types_pkg::*;

  rv32i_word  shifted;
  logic [4:0] shift_bits;

  assign shift_bits = {offset, 3'b000};

  // Bring the addressed byte or half-word down to bit 0
  assign shifted = data_rdata >> shift_bits;

  always_comb begin
    case (funct3)
      F3_B: begin
        load_data = {{24{shifted[7]}}, shifted[7:0]};
      end
      F3_BU: begin
        load_data = {24'h00_0000, shifted[7:0]};
      end
      F3_H: begin
        load_data = {{16{shifted[15]}}, shifted[15:0]};
      end
      F3_HU: begin
        load_data = {16'h0000, shifted[15:0]};
      end
      F3_W: begin
        load_data = data_rdata;
      end
      default: begin
        // Unused funct3 codes return the whole word
        load_data = data_rdata;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/mem_forward_unit.sv
`default_nettype none

module mem_forward_unit (
  input  rv32i_types_pkg::rv32i_control_word ex_ctrl,
  input  rv32i_types_pkg::rv32i_instr        ex_instr,
  input  rv32i_types_pkg::mem_wb_t           wb,
  output logic                               fwd,
  output rv32i_types_pkg::rv32i_word         fwd_data
);

  import rv32i_types_pkg::*;

  logic       ex_is_store;
  logic       wb_is_load;
  logic [4:0] wb_rd;
  logic [4:0] ex_rs2;

  assign ex_is_store = (ex_ctrl.opcode == OP_STORE) && ex_ctrl.write;

  // A bubble in MEM/WB has a zero control word and never matches here
  assign wb_is_load = (wb.ctrl.opcode == OP_LOAD) && wb.ctrl.load_regfile;

  // Register fields sit in different places in the two formats
  assign wb_rd  = wb.instr.ld.rd;
  assign ex_rs2 = ex_instr.st.rs2;

  // x0 is never written, so a load to it has nothing to forward
  assign fwd = ex_is_store && wb_is_load && (wb_rd != 5'd0) && (wb_rd == ex_rs2);

  // The register file has not seen this value yet, so it comes from MEM/WB
  assign fwd_data = wb.load_data;

endmodule

`default_nettype wire

// File: logic/mem_wb_reg.sv
`default_nettype none

module mem_wb_reg (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     advance,
  input  logic                     bubble,
  input  rv32i_types_pkg::mem_wb_t next,
  output rv32i_types_pkg::mem_wb_t wb
);

  import rv32i_types_pkg::*;

  // Writeback sees an all-zero register after reset, so nothing retires
  always_ff @(posedge clk) begin
    if (rst) begin
      wb <= '0;
    end else if (advance) begin
      wb <= next;
    end else if (bubble) begin
      // A NOP goes down the pipe while the access is outstanding.
      // Data fields keep their last values since nothing reads them
      wb.ctrl     <= '0;
      wb.instr    <= NOP_INSTR;
      wb.pc       <= '0;
      wb.pc_plus4 <= '0;
    end
  end

endmodule

`default_nettype wire

// File: logic/memory_access.sv
`default_nettype none

module memory_access (
  input  logic                               clk,
  input  logic                               rst,
  input  rv32i_types_pkg::rv32i_word         pc,
  input  rv32i_types_pkg::rv32i_instr        instr,
  input  rv32i_types_pkg::rv32i_control_word ctrl,
  input  rv32i_types_pkg::rv32i_word         rs2_data,
  input  rv32i_types_pkg::rv32i_word         alu_out,
  input  logic                               br_en,
  input  rv32i_types_pkg::rv32i_word         data_rdata,
  input  logic                               data_resp,
  output rv32i_types_pkg::rv32i_word         data_addr,
  output logic [3:0]                         data_mbe,
  output rv32i_types_pkg::rv32i_word         data_wdata,
  output logic                               data_read,
  output logic                               data_write,
  output rv32i_types_pkg::mem_wb_t           wb,
  output logic                               stall
);

  import rv32i_types_pkg::*;

  logic      advance;
  logic      bubble;
  logic      fwd;
  rv32i_word fwd_data;
  rv32i_word store_src;
  rv32i_word load_data;
  mem_wb_t   next;

  // Memory is word addressed; the low bits select lanes instead
  assign data_addr = {alu_out[31:2], 2'b00};

  mem_stage_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .data_resp  (data_resp),
    .data_read  (data_read),
    .data_write (data_write),
    .stall      (stall),
    .advance    (advance),
    .bubble     (bubble)
  );

  mem_forward_unit u_fwd (
    .ex_ctrl  (ctrl),
    .ex_instr (instr),
    .wb       (wb),
    .fwd      (fwd),
    .fwd_data (fwd_data)
  );

  // A load that just left this stage overrides the stale rs2 value
  assign store_src = fwd ? fwd_data : rs2_data;

  store_align u_store (
    .funct3     (ctrl.funct3),
    .offset     (alu_out[1:0]),
    .store_src  (store_src),
    .data_mbe   (data_mbe),
    .data_wdata (data_wdata)
  );

  load_extract u_load (
    .funct3     (ctrl.funct3),
    .offset     (alu_out[1:0]),
    .data_rdata (data_rdata),
    .load_data  (load_data)
  );

  always_comb begin
    next.ctrl       = ctrl;
    next.instr      = instr;
    next.pc         = pc;
    next.pc_plus4   = pc + 32'd4;
    next.alu_out    = alu_out;
    next.load_data  = load_data;
    next.store_data = data_wdata;
    next.data_addr  = data_addr;
    next.br_en      = br_en;
  end

  mem_wb_reg u_mem_wb (
    .clk     (clk),
    .rst     (rst),
    .advance (advance),
    .bubble  (bubble),
    .next    (next),
    .wb      (wb)
  );

endmodule

`default_nettype wire

// File: test/memory_access_sva.sv
`default_nettype none

module memory_access_sva (
  input logic                     clk,
  input logic                     rst,
  input logic                     data_resp,
  input logic                     stall,
  input logic                     data_read,
  input logic                     data_write,
  input rv32i_types_pkg::mem_wb_t wb
);

  int assert_fails = 0;

  // A response ends the wait, so the access retires into MEM/WB on that same edge
  a_resp_ends_stall: assert property (@(posedge clk) disable iff (rst)
    (data_resp && (data_read || data_write)) |=> (wb.ctrl.read || wb.ctrl.write))
    else begin
      assert_fails++;
      $error("access did not retire into wb on the edge where data_resp was high");
    end

  // Every waiting edge leaves a bubble behind in MEM/WB
  a_bubble_after_stall: assert property (@(posedge clk) disable iff (rst)
    stall |=> (wb.ctrl == '0))
    else begin
      assert_fails++;
      $error("wb.ctrl is not zero after a stalled edge");
    end

  a_one_strobe: assert property (@(posedge clk) disable iff (rst) !(data_read && data_write))
    else begin
      assert_fails++;
      $error("data_read and data_write are high together");
    end

endmodule

bind memory_access memory_access_sva u_sva (
  .clk        (clk),
  .rst        (rst),
  .data_resp  (data_resp),
  .stall      (stall),
  .data_read  (data_read),
  .data_write (data_write),
  .wb         (wb)
);

`default_nettype wire

// File: test/memory_access_tb.sv
`default_nettype none

module memory_access_tb;

  import rv32i_types_pkg::*;

  localparam int RESET_CYCLES = 3;
  localparam int MAX_LATENCY  = 3;
  localparam int MARGIN       = 10;

  typedef struct packed {
    rv32i_word         pc;
    rv32i_instr        instr;
    rv32i_control_word ctrl;
    logic              br_en;
    rv32i_word         rs2_data;
    rv32i_word         alu_out;
    rv32i_word         mem_word;
    logic [1:0]        latency;
    logic [3:0]        exp_mbe;
    rv32i_word         exp_wdata;
    rv32i_word         exp_load;
  } test_row_t;

  logic              clk;
  logic              rst;
  rv32i_word         pc;
  rv32i_instr        instr;
  rv32i_control_word ctrl;
  rv32i_word         rs2_data;
  rv32i_word         alu_out;
  logic              br_en;
  rv32i_word         data_rdata;
  logic              data_resp;
  rv32i_word         data_addr;
  logic [3:0]        data_mbe;
  rv32i_word         data_wdata;
  logic              data_read;
  logic              data_write;
  mem_wb_t           wb;
  logic              stall;

  test_row_t   rows[$];
  string       names[$];
  string       cur_name;
  int          errors;
  int          row_errors;
  int          failed_tests;
  int          cycles;
  int          cycle_limit;
  logic [31:0] rng_state;

  memory_access u_dut (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, stall never cleared in %s", cycles, cur_name);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Loads and stores use x1 as base with a zero immediate
  function automatic rv32i_instr load_op(input logic [4:0] rd, input logic [2:0] f3);
    return {12'h000, 5'd1, f3, rd, OP_LOAD};
  endfunction

  function automatic rv32i_instr store_op(input logic [4:0] rs2, input logic [2:0] f3);
    return {7'h00, rs2, 5'd1, f3, 5'h00, OP_STORE};
  endfunction

  // Control word that decode would produce; stores and branches write no register
  function automatic rv32i_control_word decode_ctrl(input rv32i_instr ins);
    rv32i_control_word c;
    c.opcode       = ins.ld.opcode;
    c.funct3       = ins.ld.funct3;
    c.read         = (ins.ld.opcode == OP_LOAD);
    c.write        = (ins.ld.opcode == OP_STORE);
    c.load_regfile = !c.write && (ins.ld.opcode != 7'b1100011);
    c.rd           = c.load_regfile ? ins.ld.rd : 5'd0;
    return c;
  endfunction

  function automatic logic [3:0] lane_mask(input logic [2:0] f3, input logic [1:0] off);
    int         bytes;
    logic [3:0] m;
    bytes = (f3 == F3_B) ? 1 : (f3 == F3_H) ? 2 : 4;
    for (int k = 0; k < 4; k++) begin
      m[k] = (k >= int'(off)) && (k < int'(off) + bytes);
    end
    return m;
  endfunction

  // Source byte n lands in lane n plus offset
  function automatic rv32i_word lane_data(input rv32i_word src, input logic [1:0] off);
    rv32i_word w;
    w = '0;
    for (int k = int'(off); k < 4; k++) begin
      w[8*k +: 8] = src[8*(k - int'(off)) +: 8];
    end
    return w;
  endfunction

  function automatic rv32i_word extend_load(input logic [2:0] f3, input logic [1:0] off,
                                            input rv32i_word w);
    logic [7:0]  b;
    logic [15:0] h;
    b = w[8*off +: 8];
    h = off[1] ? w[31:16] : w[15:0];
    case (f3)
      F3_B:    return {{24{b[7]}}, b};
      F3_BU:   return {24'h0, b};
      F3_H:    return {{16{h[15]}}, h};
      F3_HU:   return {16'h0, h};
      default: return w;
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error %s %s: expected %h, actual %h", cur_name, what, expected, actual);
      errors++;
      row_errors++;
    end
  endtask

  task automatic report_test();
    if (row_errors == 0) begin
      $display("%s passed", cur_name);
    end else begin
      $display("%s failed with %0d mismatches", cur_name, row_errors);
      failed_tests++;
    end
  endtask

  task automatic add_row(input string name, input rv32i_instr ins, input rv32i_word rs2,
                         input rv32i_word alu, input rv32i_word mem, input int lat,
                         input logic [3:0] mbe, input rv32i_word wdata, input rv32i_word ld);
    test_row_t r;
    r.pc        = 32'h0000_0100 + 32'(4 * rows.size());
    r.instr     = ins;
    r.ctrl      = decode_ctrl(ins);
    r.br_en     = (ins.ld.opcode == 7'b1100011);
    r.rs2_data  = rs2;
    r.alu_out   = alu;
    r.mem_word  = mem;
    r.latency   = 2'(lat);
    r.exp_mbe   = mbe;
    r.exp_wdata = wdata;
    r.exp_load  = ld;
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic add_random_row(input string name, input rv32i_instr ins,
                                input rv32i_word alu, input int lat);
    rv32i_word         src;
    rv32i_word         word;
    rv32i_control_word c;
    rng_state = xorshift32(rng_state);
    src       = rng_state;
    rng_state = xorshift32(rng_state);
    word      = rng_state;
    c         = decode_ctrl(ins);
    add_row(name, ins, src, alu, word, lat,
            c.write ? lane_mask(c.funct3, alu[1:0]) : 4'h0,
            c.write ? lane_data(src, alu[1:0]) : 32'h0,
            c.read ? extend_load(c.funct3, alu[1:0], word) : 32'h0);
  endtask

  // Entered a little after a rising edge; returns at the same point after the row retires
  task automatic run_row(input int idx);
    test_row_t r;
    logic      req;
    logic      done;
    int        cyc;
    r          = rows[idx];
    cur_name   = names[idx];
    row_errors = 0;
    req        = r.ctrl.read | r.ctrl.write;
    pc         = r.pc;
    instr      = r.instr;
    ctrl       = r.ctrl;
    rs2_data   = r.rs2_data;
    alu_out    = r.alu_out;
    br_en      = r.br_en;
    data_rdata = r.mem_word;
    // Memory model answers once the row's latency has passed
    data_resp  = req && (r.latency == 0);
    cyc        = 0;
    done       = 1'b0;
    while (!done) begin
      #15;
      check_value("stall", req && (cyc < r.latency), stall);
      check_value("data_read", r.ctrl.read, data_read);
      check_value("data_write", r.ctrl.write, data_write);
      check_value("data_addr", r.alu_out & 32'hffff_fffc, data_addr);
      if (r.ctrl.write) begin
        check_value("data_mbe", r.exp_mbe, data_mbe);
        check_value("data_wdata", r.exp_wdata, data_wdata);
      end
      if (cyc > 0) begin
        check_value("bubble ctrl", 32'h0, wb.ctrl);
        check_value("bubble instr", NOP_INSTR, wb.instr);
        check_value("bubble pc", 32'h0, wb.pc);
        check_value("bubble pc_plus4", 32'h0, wb.pc_plus4);
      end
      if (stall) begin
        @(posedge clk);
        #5;
        cyc++;
        data_resp = req && (cyc >= r.latency);
      end else begin
        done = 1'b1;
      end
    end
    @(posedge clk);
    #5;
    data_resp = 1'b0;
    check_value("wb.ctrl", r.ctrl, wb.ctrl);
    check_value("wb.instr", r.instr, wb.instr);
    check_value("wb.pc", r.pc, wb.pc);
    check_value("wb.pc_plus4", r.pc + 32'd4, wb.pc_plus4);
    check_value("wb.alu_out", r.alu_out, wb.alu_out);
    check_value("wb.br_en", r.br_en, wb.br_en);
    check_value("wb.data_addr", r.alu_out & 32'hffff_fffc, wb.data_addr);
    if (r.ctrl.read) check_value("wb.load_data", r.exp_load, wb.load_data);
    if (r.ctrl.write) check_value("wb.store_data", r.exp_wdata, wb.store_data);
    report_test();
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    pc           = '0;
    instr        = '0;
    ctrl         = '0;
    rs2_data     = '0;
    alu_out      = '0;
    br_en        = 1'b0;
    data_rdata   = '0;
    data_resp    = 1'b0;
    errors       = 0;
    failed_tests = 0;
    cycles       = 0;
    cur_name     = "reset";
    rng_state    = 32'd46262;

    // Name, instruction, rs2_data, alu_out, memory word, latency, mbe, wdata, load_data
    add_row("alu_add", 32'h0020_82b3, 0, 'h1234_5678, 0, 0, 4'h0, 0, 0);
    add_row("branch", 32'h0020_8463, 0, 'h0000_0108, 0, 0, 4'h0, 0, 0);
    add_row("sb_off1", store_op(9, F3_B), 'h1122_33a5, 'h2001, 0, 0, 4'b0010, 'h2233_a500, 0);
    add_row("sb_off3", store_op(9, F3_B), 'hcafe_f00d, 'h2003, 0, 2, 4'b1000, 'h0d00_0000, 0);
    add_row("sh_off2", store_op(9, F3_H), 'hdead_beef, 'h2012, 0, 0, 4'b1100, 'hbeef_0000, 0);
    add_row("sw_off0", store_op(9, F3_W), 'h0bad_f00d, 'h2020, 0, 1, 4'b1111, 'h0bad_f00d, 0);
    add_row("lb_off3", load_op(10, F3_B), 0, 'h3003, 'h80ff_1234, 0, 4'h0, 0, 'hffff_ff80);
    add_row("lbu_off3", load_op(10, F3_BU), 0, 'h3007, 'h80ff_1234, 3, 4'h0, 0, 'h0000_0080);
    add_row("lh_off2", load_op(10, F3_H), 0, 'h3012, 'h9abc_5678, 0, 4'h0, 0, 'hffff_9abc);
    add_row("lhu_off2", load_op(10, F3_HU), 0, 'h3016, 'h9abc_5678, 1, 4'h0, 0, 'h0000_9abc);
    add_row("lw_off0", load_op(10, F3_W), 0, 'h3020, 'h7654_3210, 2, 4'h0, 0, 'h7654_3210);
    // Store right behind a load of its rs2 takes the loaded word
    add_row("lw_x7", load_op(7, F3_W), 0, 'h4000, 'h1357_9bdf, 1, 4'h0, 0, 'h1357_9bdf);
    add_row("sh_fwd_x7", store_op(7, F3_H), 'haaaa_5555, 'h4102, 0, 0, 4'b1100, 'h9bdf_0000, 0);
    add_row("lw_x0", load_op(0, F3_W), 0, 'h4004, 'h2468_ace0, 0, 4'h0, 0, 'h2468_ace0);
    add_row("sw_x0", store_op(0, F3_W), 0, 'h4104, 0, 0, 4'b1111, 0, 0);
    add_row("lw_x7_again", load_op(7, F3_W), 0, 'h4008, 'h0f0f_1e1e, 0, 4'h0, 0, 'h0f0f_1e1e);
    add_row("sw_x8", store_op(8, F3_W), 'h5a5a_a5a5, 'h410c, 0, 0, 4'b1111, 'h5a5a_a5a5, 0);
    add_random_row("rnd_sb_off0", store_op(9, F3_B), 'h5000, 0);
    add_random_row("rnd_sb_off2", store_op(9, F3_B), 'h5006, 1);
    add_random_row("rnd_sh_off0", store_op(9, F3_H), 'h5008, 2);
    add_random_row("rnd_lh_off0", load_op(11, F3_H), 'h500c, 1);
    add_random_row("rnd_lbu_off1", load_op(11, F3_BU), 'h5011, 3);

    cycle_limit = rows.size() * (MAX_LATENCY + 2) + RESET_CYCLES + MARGIN;

    repeat (RESET_CYCLES) @(posedge clk);
    #5;
    rst        = 1'b0;
    row_errors = 0;
    #10;
    check_value("wb all zero", 32'h1, {31'h0, wb == '0});
    check_value("data_read", 32'h0, data_read);
    check_value("data_write", 32'h0, data_write);
    check_value("stall", 32'h0, stall);
    report_test();
    @(posedge clk);
    #5;

    foreach (rows[i]) begin
      run_row(i);
    end

    $display("Tests run %0d, failed %0d, mismatches %0d, assertion failures %0d",
             rows.size() + 1, failed_tests, errors, u_dut.u_sva.assert_fails);
    if (errors == 0 && u_dut.u_sva.assert_fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
logic/rv32i_types_pkg.sv
logic/mem_stage_ctrl.sv
logic/store_align.sv
logic/load_extract.sv
logic/mem_forward_unit.sv
logic/mem_wb_reg.sv
logic/memory_access.sv
test/memory_access_sva.sv
test/memory_access_tb.sv
